// File: filelist.f
hw/rspOrderPkg.sv
hw/reqRetag.sv
hw/reorderScoreboard.sv
hw/rspSequencer.sv
hw/rspOrderTop.sv
verification/memModel.sv
verification/rspOrderTb.sv

// File: Makefile
# Verilator build and run for the read response ordering shim

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= rspOrderTb
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJDIR)

// File: verification/rspOrderTb.sv
// ==============================
// Testbench for the read response ordering shim
// Issues client reads, lets the memory model answer
// out of order and checks order, tags, data, slot use
// and almFull
// ==============================

module rspOrderTb
    import rspOrderPkg::*;
();

    // Cycle limit for every wait
    localparam int maxWait = 2000;

    logic clk = 1'b0;
    logic arstN;
    logic reqValid;
    tRdReq req;
    logic almFull;
    logic rspValid;
    tRdRsp rsp;
    logic memReqValid;
    tMemReq memReq;
    logic memAlmFull;
    logic memRspValid;
    tMemRsp memRsp;
    logic holdRsp;
    logic busyEn;

    integer seed = 32'hfbac_4cac;
    tClientTag nextTag;

    // Reference state, written only by the monitor
    tRdReq expQ[$];
    logic [nSlots-1:0] atMem = '0;
    int issued = 0;
    int retired = 0;
    int reserveUsed = 0;
    logic almFullSeen = 1'b0;
    tRdReq expReq;
    logic expAlmFull;

    rspOrderTop rspOrderTop_inst (
        .clk         (clk),
        .arstN       (arstN),
        .reqValid    (reqValid),
        .req         (req),
        .almFull     (almFull),
        .rspValid    (rspValid),
        .rsp         (rsp),
        .memReqValid (memReqValid),
        .memReq      (memReq),
        .memAlmFull  (memAlmFull),
        .memRspValid (memRspValid),
        .memRsp      (memRsp)
    );

    memModel memModel_inst (
        .clk         (clk),
        .arstN       (arstN),
        .memReqValid (memReqValid),
        .memReq      (memReq),
        .holdRsp     (holdRsp),
        .busyEn      (busyEn),
        .memAlmFull  (memAlmFull),
        .memRspValid (memRspValid),
        .memRsp      (memRsp)
    );

    always #10 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // ==============================
    // Monitor sampled mid-cycle
    // ==============================

    always @(negedge clk)
    begin
        // Quiet shim until the first read
        if (issued == 0)
            assert (!rspValid && !almFull)
                else abortRun($sformatf("Error: rspValid %h almFull %h before any read",
                    rspValid, almFull));
        // Each response must match the oldest read still waiting
        if (rspValid)
        begin
            assert (expQ.size() > 0)
                else abortRun("A response arrived with no read outstanding");
            expReq = expQ.pop_front();
            retired++;
            assert (rsp.tag == expReq.tag)
                else abortRun($sformatf("Error: rsp.tag got %h, expected %h",
                    rsp.tag, expReq.tag));
            assert (rsp.data == {expReq.addr, expReq.addr})
                else abortRun($sformatf("Error: rsp.data got %h, expected %h", rsp.data,
                    {expReq.addr, expReq.addr}));
        end
        // Slots in use before this cycle's read lands and after this cycle's pop
        expAlmFull = memAlmFull || (nSlots - (issued - retired)) <= almFullReserve;
        assert (almFull == expAlmFull)
            else abortRun($sformatf("Error: almFull got %h, expected %h", almFull, expAlmFull));
        // The memory request follows the client request in the same cycle
        assert (memReqValid == reqValid)
            else abortRun($sformatf("Error: memReqValid got %h, expected %h",
                memReqValid, reqValid));
        if (memRspValid)
        begin
            assert (atMem[memRsp.slot])
                else abortRun("Memory answered a slot that had no read outstanding");
            atMem[memRsp.slot] = 1'b0;
        end
        if (memReqValid)
        begin
            assert (memReq.addr == req.addr)
                else abortRun($sformatf("Error: memReq.addr got %h, expected %h",
                    memReq.addr, req.addr));
            assert (!atMem[memReq.slot])
                else abortRun($sformatf("Error: memReq.slot %h is already outstanding",
                    memReq.slot));
            atMem[memReq.slot] = 1'b1;
        end
        if (reqValid)
        begin
            expQ.push_back(req);
            issued++;
            assert (issued - retired <= nSlots)
                else abortRun("More reads outstanding than there are reorder slots");
        end
        // Reads spent from the reserve since almFull went high
        almFullSeen = almFull;
        if (!almFull)
            reserveUsed = 0;
        else if (reqValid)
            reserveUsed++;
    end

    // ==============================
    // Client stimulus
    // ==============================

    // Sends count reads and skips a cycle with gapPct percent chance
    task automatic sendReads(input int count, input int gapPct);
        int sent;
        int waited;
        sent = 0;
        waited = 0;
        while (sent < count && waited < maxWait)
        begin
            @(posedge clk);
            #2;
            reqValid = 1'b0;
            if (almFullSeen && reserveUsed >= almFullReserve)
            begin
                waited++;
            end
            else if ($unsigned($random(seed)) % 100 >= gapPct)
            begin
                reqValid = 1'b1;
                req.addr = tAddr'($random(seed));
                req.tag = nextTag;
                nextTag++;
                sent++;
                waited = 0;
            end
        end
        @(posedge clk);
        #2;
        reqValid = 1'b0;
        if (sent < count)
            abortRun("Timeout while the client waited for almFull to fall");
    endtask

    task automatic waitDrained();
        int cycles;
        cycles = 0;
        while ((expQ.size() > 0 || atMem != '0) && cycles < maxWait)
        begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (expQ.size() > 0 || atMem != '0)
            abortRun("Timeout while waiting for outstanding reads to return");
    endtask

    initial
    begin
        arstN = 1'b0;
        reqValid = 1'b0;
        req = '0;
        holdRsp = 1'b0;
        busyEn = 1'b0;
        nextTag = '0;
        repeat (2) @(posedge clk);
        #2;
        arstN = 1'b1;
        repeat (4) @(posedge clk);

        // Mixed traffic with memory answering out of order
        sendReads(60, 30);
        waitDrained();

        // With memory silent the slots fill and the reserve gets used
        holdRsp = 1'b1;
        sendReads(nSlots, 0);
        assert (almFullSeen && reserveUsed == almFullReserve)
            else abortRun("The burst never reached the almost-full point");
        repeat (4) @(posedge clk);
        #2;
        holdRsp = 1'b0;
        waitDrained();

        // Memory back-pressure on an empty scoreboard followed by reserve reads only
        busyEn = 1'b1;
        repeat (6) @(posedge clk);
        sendReads(almFullReserve, 0);
        busyEn = 1'b0;
        waitDrained();

        sendReads(40, 10);
        waitDrained();

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: verification/memModel.sv
// ==============================
// Testbench memory model
// Collects read requests and answers them one at a
// time in random order after random delays
// ==============================

module memModel
    import rspOrderPkg::*;
(
    input  logic clk,
    input  logic arstN,

    // Requests from the shim
    input  logic memReqValid,
    input  tMemReq memReq,

    // holdRsp silences memory and busyEn raises memAlmFull
    input  logic holdRsp,
    input  logic busyEn,

    // Back-pressure and responses toward the shim
    output logic memAlmFull,
    output logic memRspValid,
    output tMemRsp memRsp
);

    // Reads accepted and not answered yet
    tMemReq pending[$];

    integer seed = 32'hfbac_4cac;
    int pick;
    tMemReq sel;
    logic holdNow;
    logic busyNow;

    // Requests are taken mid-cycle when the combinational retag has settled
    always @(negedge clk)
    begin
        if (arstN && memReqValid)
            pending.push_back(memReq);
    end

    // ==============================
    // Response generator
    // ==============================

    initial
    begin
        memAlmFull = 1'b0;
        memRspValid = 1'b0;
        memRsp = '0;
        forever
        begin
            @(posedge clk);
            // Controls are taken at the edge and change later in the cycle
            holdNow = holdRsp;
            busyNow = busyEn;
            #2;
            memAlmFull = busyNow;
            memRspValid = 1'b0;
            // Roughly one cycle in three answers some pending read
            if (arstN && !holdNow && pending.size() > 0 && ($unsigned($random(seed)) % 3) == 0)
            begin
                pick = $unsigned($random(seed)) % pending.size();
                sel = pending[pick];
                pending.delete(pick);
                memRspValid = 1'b1;
                memRsp.slot = sel.slot;
                // Line data is the address in both halves
                memRsp.data = {sel.addr, sel.addr};
            end
        end
    end

endmodule

// File: hw/rspOrderTop.sv
// ==============================
// Read response ordering shim
// Client reads go to memory tagged with reorder slots,
// and out-of-order memory responses return to the client
// in request order with the client tags restored
// ==============================

module rspOrderTop
    import rspOrderPkg::*;
(
    input  logic clk,
    input  logic arstN,

    // Client port
    input  logic reqValid,
    input  tRdReq req,
    output logic almFull,
    output logic rspValid,
    output tRdRsp rsp,

    // Memory port
    output logic memReqValid,
    output tMemReq memReq,
    input  logic memAlmFull,
    input  logic memRspValid,
    input  tMemRsp memRsp
);

    // Allocation between retagger and scoreboard
    tSlotIdx allocIdx;
    logic notFull;
    logic allocEn;
    tClientTag allocTag;

    // Head of the scoreboard toward the sequencer
    logic popEn;
    logic headReady;
    tClientTag headTag;
    tLineData headData;

    // ==============================
    // Request path
    // ==============================

    reqRetag reqRetag_inst (
        .reqValid    (reqValid),
        .req         (req),
        .almFull     (almFull),
        .memAlmFull  (memAlmFull),
        .allocIdx    (allocIdx),
        .notFull     (notFull),
        .allocEn     (allocEn),
        .allocTag    (allocTag),
        .memReqValid (memReqValid),
        .memReq      (memReq)
    );

    // Memory responses fill the scoreboard directly
    reorderScoreboard reorderScoreboard_inst (
        .clk       (clk),
        .arstN     (arstN),
        .allocEn   (allocEn),
        .allocTag  (allocTag),
        .allocIdx  (allocIdx),
        .notFull   (notFull),
        .fillEn    (memRspValid),
        .fill      (memRsp),
        .popEn     (popEn),
        .headReady (headReady),
        .headTag   (headTag),
        .headData  (headData)
    );

    // ==============================
    // Response path
    // ==============================

    rspSequencer rspSequencer_inst (
        .clk       (clk),
        .arstN     (arstN),
        .headReady (headReady),
        .headTag   (headTag),
        .headData  (headData),
        .popEn     (popEn),
        .rspValid  (rspValid),
        .rsp       (rsp)
    );

endmodule

// File: hw/rspSequencer.sv
// ==============================
// Response sequencer
// Drains the scoreboard head in request order and
// registers one client response per cycle
// ==============================

module rspSequencer
    import rspOrderPkg::*;
(
    input  logic clk,
    input  logic arstN,

    // Head of the scoreboard
    input  logic headReady,
    input  tClientTag headTag,
    input  tLineData headData,
    output logic popEn,

    // Ordered response toward the client
    output logic rspValid,
    output tRdRsp rsp
);

    // ==============================
    // Pop control
    // ==============================

    // The client has no ready signal, so a ready head always leaves.
    // Back-to-back pops drain a run of filled slots at one per cycle
    assign popEn = headReady;

    // ==============================
    // Response register
    // ==============================

    // Valid strobe follows the pop by one cycle
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            rspValid <= 1'b0;
        end
        else
        begin
            rspValid <= popEn;
        end
    end

    // Tag and data of the head are captured on each pop
    always_ff @(posedge clk)
    begin
        if (popEn)
        begin
            // Original client tag restored from the scoreboard
            rsp.tag <= headTag;
            rsp.data <= headData;
        end
    end

endmodule

// File: hw/reorderScoreboard.sv
// ==============================
// Reorder scoreboard
// Slot storage for outstanding reads. Slots are handed
// out in order at the tail, filled in any order by memory
// and drained in order from the head
// ==============================

module reorderScoreboard
    import rspOrderPkg::*;
(
    input  logic clk,
    input  logic arstN,

    // Allocation from the retagger
    input  logic allocEn,
    input  tClientTag allocTag,
    output tSlotIdx allocIdx,
    output logic notFull,

    // Fill from the memory response
    input  logic fillEn,
    input  tMemRsp fill,

    // In-order drain by the sequencer
    input  logic popEn,
    output logic headReady,
    output tClientTag headTag,
    output tLineData headData
);

    // Occupancy needs one bit more than a slot index to hold nSlots
    typedef logic [slotIdxBits:0] tSlotCnt;

    // Storage arrays, written by allocation and by fill
    tClientTag tagArr [nSlots];
    tLineData dataArr [nSlots];

    // One ready bit per slot, set once its data has arrived
    logic [nSlots-1:0] readyBits;

    tSlotIdx tail;
    tSlotIdx head;
    tSlotCnt count;
    tSlotCnt freeCnt;

    // Next slot index with a wrap at the last slot
    function automatic tSlotIdx nextIdx(input tSlotIdx idx);
        tSlotIdx res;
        if (idx == tSlotIdx'(nSlots - 1))
            res = '0;
        else
            res = idx + 1'b1;
        return res;
    endfunction

    // ==============================
    // Tail and occupancy
    // ==============================

    assign allocIdx = tail;

    // Keep a reserve of free slots for reads already on their way
    assign freeCnt = tSlotCnt'(nSlots) - count;
    assign notFull = freeCnt > tSlotCnt'(almFullReserve);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            tail <= '0;
            head <= '0;
            count <= '0;
        end
        else
        begin
            if (allocEn)
                tail <= nextIdx(tail);

            if (popEn)
                head <= nextIdx(head);

            // Allocation and pop in one cycle leave the count unchanged
            case ({allocEn, popEn})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ==============================
    // Slot storage
    // ==============================

    // The client tag is parked in the slot at allocation time
    always_ff @(posedge clk)
    begin
        if (allocEn)
            tagArr[tail] <= allocTag;
    end

    // Memory data lands in the slot named by the response
    always_ff @(posedge clk)
    begin
        if (fillEn)
            dataArr[fill.slot] <= fill.data;
    end

    // A pop clears the head ready bit and a fill marks its own slot
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            readyBits <= '0;
        end
        else
        begin
            if (popEn)
                readyBits[head] <= 1'b0;
            if (fillEn)
                readyBits[fill.slot] <= 1'b1;
        end
    end

    // ==============================
    // Head view
    // ==============================

    // The oldest outstanding read can leave once its data is present
    assign headReady = readyBits[head];
    assign headTag = tagArr[head];
    assign headData = dataArr[head];

endmodule

// File: hw/reqRetag.sv
// ==============================
// Request retagger
// Replaces the client tag of each read with the reorder
// slot it is given and merges the two back-pressure
// sources into the client's almost-full
// ==============================

module reqRetag
    import rspOrderPkg::*;
(
    // Client request side
    input  logic reqValid,
    input  tRdReq req,
    output logic almFull,

    // Back-pressure from memory
    input  logic memAlmFull,

    // Scoreboard allocation port
    input  tSlotIdx allocIdx,
    input  logic notFull,
    output logic allocEn,
    output tClientTag allocTag,

    // Request toward memory
    output logic memReqValid,
    output tMemReq memReq
);

    // ==============================
    // Slot allocation
    // ==============================

    // Every client read claims the tail slot at the next edge
    assign allocEn = reqValid;

    // The original tag waits in the scoreboard until the response is returned
    assign allocTag = req.tag;

    // ==============================
    // Forwarding toward memory
    // ==============================

    // Same cycle as the client request with only the tag field changed
    assign memReqValid = reqValid;

    always_comb
    begin
        memReq.addr = req.addr;
        // Memory sees the slot index where the client tag used to be
        memReq.slot = allocIdx;
    end

    // Either memory or the scoreboard running low on slots stops the client
    assign almFull = memAlmFull || !notFull;

endmodule

// File: hw/rspOrderPkg.sv
// ==============================
// Read response ordering shim package
// Widths, slot counts and the request and response
// structs shared by the retagger, scoreboard and sequencer
// ==============================

package rspOrderPkg;

    // ==============================
    // Sizes
    // ==============================

    // Number of reorder slots, which bounds the reads outstanding at memory
    localparam int nSlots = 16;
    localparam int slotIdxBits = 4;

    // Client tag, line data and address widths
    localparam int tagBits = 8;
    localparam int dataBits = 32;
    localparam int addrBits = 16;

    // Reads the client may still issue after almFull rises.
    // The shim raises almFull while no more than this many slots are free
    localparam int almFullReserve = 2;

    // ==============================
    // Vector types
    // ==============================

    typedef logic [slotIdxBits-1:0] tSlotIdx;
    typedef logic [tagBits-1:0] tClientTag;
    typedef logic [dataBits-1:0] tLineData;
    typedef logic [addrBits-1:0] tAddr;

    // ==============================
    // Transfer structs
    // ==============================

    // Read request as issued by the client
    typedef struct packed {
        tAddr addr;
        tClientTag tag;
    } tRdReq;

    // Read request toward memory, tagged with the reorder slot
    typedef struct packed {
        tAddr addr;
        tSlotIdx slot;
    } tMemReq;

    // Memory response, returned in any order
    typedef struct packed {
        tSlotIdx slot;
        tLineData data;
    } tMemRsp;

    // In-order response toward the client with its own tag restored
    typedef struct packed {
        tClientTag tag;
        tLineData data;
    } tRdRsp;

endpackage
